// ==== Bender.yml ====
package:
  name: fifo_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/fifo_ctrl_pkg.sv
      - design/reg_bus_if.sv
      - design/chan_if.sv
      - design/axi_lite_port.sv
      - design/ctrl_regs.sv
      - design/fifo_channel.sv
      - design/fifo_ctrl_top.sv
      - target: test
        files:
          - verification/tb_fifo_ctrl.sv

// ==== design/axi_lite_port.sv ====
`include "fifo_ctrl_consts.svh"

module axi_lite_port (
  input  logic                    clk,
  input  logic                    rst_n,
  // Write address channel
  input  logic [`FC_ADDR_W-1:0]   awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  // Write data channel
  input  logic [`FC_DATA_W-1:0]   wdata,
  input  logic [`FC_DATA_W/8-1:0] wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  // Write response channel
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  // Read address channel
  input  logic [`FC_ADDR_W-1:0]   araddr,
  input  logic                    arvalid,
  output logic                    arready,
  // Read data channel
  output logic [`FC_DATA_W-1:0]   rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  reg_bus_if.port                 bus
);

  logic [`FC_ADDR_W-1:0] wr_addr_q;
  logic                  aw_hs;
  logic                  w_hs;

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      // Address accepted a cycle after awvalid, held until the data beat
      if (awvalid) begin
        awready <= 1'b1;
      end else if (w_hs) begin
        awready <= 1'b0;
      end
      if (aw_hs) begin
        wready <= 1'b1;
      end else if (wvalid) begin
        wready <= 1'b0;
      end
      // Response held until the master takes it
      if (w_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  assign bus.wr_en   = w_hs;
  assign bus.wr_addr = wr_addr_q;
  assign bus.wr_data = wdata;
  assign bus.wr_strb = wstrb;

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  assign bus.rd_en   = arvalid & arready;
  assign bus.rd_addr = araddr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end else begin
      // One read in flight at a time
      if (arvalid) begin
        arready <= 1'b0;
      end else if (rvalid && rready) begin
        arready <= 1'b1;
      end
      if (bus.rd_en) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_addr_q <= awaddr;
    end
    if (bus.rd_en) begin
      rdata <= bus.rd_data;
    end
  end

  assign bresp = 2'b00;
  assign rresp = 2'b00;

endmodule

// ==== design/chan_if.sv ====
`include "fifo_ctrl_consts.svh"

interface chan_if;

  // Register block to channel
  logic [`FC_DATA_W-1:0] control;
  logic [`FC_CMD_W-1:0]  cmd;

  // Channel to register block
  logic [`FC_DATA_W-1:0] status;
  logic [`FC_DATA_W-1:0] sts_data;
  logic                  idle;

  modport regs (
    output control, cmd,
    input  status, sts_data, idle
  );

  modport chan (
    input  control, cmd,
    output status, sts_data, idle
  );

endinterface

// ==== design/ctrl_regs.sv ====
`include "fifo_ctrl_consts.svh"

module ctrl_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  reg_bus_if.regs               bus,
  chan_if.regs                  tx,
  chan_if.regs                  rx,
  input  logic [`FC_DATA_W-1:0] action_type,
  input  logic [`FC_DATA_W-1:0] action_version,
  output logic [`FC_DATA_W-1:0] snap_context
);

  localparam int W = `FC_DATA_W;

  logic [W-1:0]                  snap_ctrl_q;
  logic [W-1:0]                  int_enable_q;
  logic [W-1:0]                  context_q;
  logic [W-1:0]                  tx_ctrl_q;
  logic [W-1:0]                  rx_ctrl_q;
  logic [`FC_CMD_WORDS*W-1:0]    tx_cmd_q;
  logic [`FC_CMD_WORDS*W-1:0]    rx_cmd_q;
  logic [W-1:0]                  wr_mask;
  logic [W-1:0]                  snap_ctrl_rd;
  logic                          start_q;
  logic                          idle_q;
  fifo_ctrl_pkg::reg_addr_e      wr_sel;
  fifo_ctrl_pkg::reg_addr_e      rd_sel;

  // Byte lanes without a strobe keep their old value
  function automatic logic [W-1:0] merge(input logic [W-1:0] old_v);
    return (bus.wr_data & wr_mask) | (old_v & ~wr_mask);
  endfunction

  always_comb begin
    for (int b = 0; b < W/8; b++) begin
      wr_mask[8*b +: 8] = {8{bus.wr_strb[b]}};
    end
  end

  assign wr_sel = fifo_ctrl_pkg::reg_addr_e'(bus.wr_addr);
  assign rd_sel = fifo_ctrl_pkg::reg_addr_e'(bus.rd_addr);

  ////////////////////////////////////////
  // Register storage
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      snap_ctrl_q  <= '0;
      int_enable_q <= '0;
      context_q    <= '0;
      tx_ctrl_q    <= '0;
      rx_ctrl_q    <= '0;
      tx_cmd_q     <= '0;
      rx_cmd_q     <= '0;
    end else if (bus.wr_en) begin
      case (wr_sel)
        fifo_ctrl_pkg::CONTROL:    snap_ctrl_q      <= merge(snap_ctrl_q);
        fifo_ctrl_pkg::INT_ENABLE: int_enable_q     <= merge(int_enable_q);
        fifo_ctrl_pkg::CONTEXT:    context_q        <= merge(context_q);
        fifo_ctrl_pkg::TX_CONTROL: tx_ctrl_q        <= merge(tx_ctrl_q);
        fifo_ctrl_pkg::TX_CMD0:    tx_cmd_q[0 +: W]   <= merge(tx_cmd_q[0 +: W]);
        fifo_ctrl_pkg::TX_CMD1:    tx_cmd_q[W +: W]   <= merge(tx_cmd_q[W +: W]);
        fifo_ctrl_pkg::TX_CMD2:    tx_cmd_q[2*W +: W] <= merge(tx_cmd_q[2*W +: W]);
        fifo_ctrl_pkg::TX_CMD3:    tx_cmd_q[3*W +: W] <= merge(tx_cmd_q[3*W +: W]);
        fifo_ctrl_pkg::RX_CONTROL: rx_ctrl_q        <= merge(rx_ctrl_q);
        fifo_ctrl_pkg::RX_CMD0:    rx_cmd_q[0 +: W]   <= merge(rx_cmd_q[0 +: W]);
        fifo_ctrl_pkg::RX_CMD1:    rx_cmd_q[W +: W]   <= merge(rx_cmd_q[W +: W]);
        fifo_ctrl_pkg::RX_CMD2:    rx_cmd_q[2*W +: W] <= merge(rx_cmd_q[2*W +: W]);
        fifo_ctrl_pkg::RX_CMD3:    rx_cmd_q[3*W +: W] <= merge(rx_cmd_q[3*W +: W]);
        default: ;
      endcase
    end
  end

  // SNAP start mirror and idle, idle when neither channel has requests out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      idle_q  <= 1'b0;
    end else begin
      start_q <= snap_ctrl_q[0];
      idle_q  <= tx.idle & rx.idle;
    end
  end

  // Bit 3 ready is tied high, bit 1 done is never set
  assign snap_ctrl_rd = {snap_ctrl_q[W-1:4], 1'b1, idle_q, 1'b0, start_q};

  assign tx.control   = tx_ctrl_q;
  assign tx.cmd       = tx_cmd_q[`FC_CMD_W-1:0];
  assign rx.control   = rx_ctrl_q;
  assign rx.cmd       = rx_cmd_q[`FC_CMD_W-1:0];
  assign snap_context = context_q;

  ////////////////////////////////////////
  // Read multiplexer
  ////////////////////////////////////////

  always_comb begin
    case (rd_sel)
      fifo_ctrl_pkg::CONTROL:        bus.rd_data = snap_ctrl_rd;
      fifo_ctrl_pkg::INT_ENABLE:     bus.rd_data = int_enable_q;
      fifo_ctrl_pkg::ACTION_TYPE:    bus.rd_data = action_type;
      fifo_ctrl_pkg::ACTION_VERSION: bus.rd_data = action_version;
      fifo_ctrl_pkg::CONTEXT:        bus.rd_data = context_q;
      fifo_ctrl_pkg::TX_STATUS:      bus.rd_data = tx.status;
      fifo_ctrl_pkg::TX_CONTROL:     bus.rd_data = tx_ctrl_q;
      fifo_ctrl_pkg::TX_CMD0:        bus.rd_data = tx_cmd_q[0 +: W];
      fifo_ctrl_pkg::TX_CMD1:        bus.rd_data = tx_cmd_q[W +: W];
      fifo_ctrl_pkg::TX_CMD2:        bus.rd_data = tx_cmd_q[2*W +: W];
      fifo_ctrl_pkg::TX_CMD3:        bus.rd_data = tx_cmd_q[3*W +: W];
      fifo_ctrl_pkg::TX_STS_DATA:    bus.rd_data = tx.sts_data;
      fifo_ctrl_pkg::RX_STATUS:      bus.rd_data = rx.status;
      fifo_ctrl_pkg::RX_CONTROL:     bus.rd_data = rx_ctrl_q;
      fifo_ctrl_pkg::RX_CMD0:        bus.rd_data = rx_cmd_q[0 +: W];
      fifo_ctrl_pkg::RX_CMD1:        bus.rd_data = rx_cmd_q[W +: W];
      fifo_ctrl_pkg::RX_CMD2:        bus.rd_data = rx_cmd_q[2*W +: W];
      fifo_ctrl_pkg::RX_CMD3:        bus.rd_data = rx_cmd_q[3*W +: W];
      fifo_ctrl_pkg::RX_STS_DATA:    bus.rd_data = rx.sts_data;
      default:                       bus.rd_data = `FC_RD_DEFAULT;
    endcase
  end

endmodule

// ==== design/fifo_channel.sv ====
`include "fifo_ctrl_consts.svh"

module fifo_channel #(
  parameter int STS_W = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  chan_if.chan                 ctl,
  // Command FIFO write side
  output logic                 cmd_tvalid,
  input  logic                 cmd_tready,
  output logic [`FC_CMD_W-1:0] cmd_tdata,
  input  logic                 cmd_prog_full,
  // Status FIFO read side
  input  logic                 sts_tvalid,
  output logic                 sts_tready,
  input  logic [STS_W-1:0]     sts_tdata,
  input  logic                 sts_prog_full
);

  logic                  push_seen_q;
  logic                  arm_seen_q;
  logic                  captured_q;
  logic                  vld_mirror_q;
  logic                  rdy_mirror_q;
  logic                  cmd_pf_q;
  logic                  sts_pf_q;
  logic [`FC_CNT_W-1:0]  req_cnt_q;
  logic [`FC_CNT_W-1:0]  cnt_mirror_q;
  logic [`FC_DATA_W-1:0] sts_data_q;
  logic                  push_rise;
  logic                  arm_rise;
  logic                  sts_acc;

  // Edges seen against the control value of the previous cycle
  assign push_rise = ctl.control[`FC_PUSH_BIT] & ~push_seen_q;
  assign arm_rise  = ctl.control[`FC_ARM_BIT] & ~arm_seen_q;
  assign sts_acc   = sts_tvalid & sts_tready;

  ////////////////////////////////////////
  // Command FIFO push
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_seen_q  <= 1'b0;
      cmd_tvalid   <= 1'b0;
      vld_mirror_q <= 1'b0;
      rdy_mirror_q <= 1'b0;
      cmd_pf_q     <= 1'b0;
    end else begin
      push_seen_q <= ctl.control[`FC_PUSH_BIT];
      if (push_rise) begin
        cmd_tvalid <= 1'b1;
      end else if (cmd_tvalid && cmd_tready) begin
        cmd_tvalid <= 1'b0;
      end
      vld_mirror_q <= cmd_tvalid;
      rdy_mirror_q <= cmd_tready;
      cmd_pf_q     <= cmd_prog_full;
    end
  end

  always_ff @(posedge clk) begin
    cmd_tdata <= ctl.cmd;
  end

  ////////////////////////////////////////
  // Status FIFO capture
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arm_seen_q <= 1'b0;
      captured_q <= 1'b0;
      sts_tready <= 1'b1;
      sts_pf_q   <= 1'b0;
      sts_data_q <= '0;
    end else begin
      arm_seen_q <= ctl.control[`FC_ARM_BIT];
      // Re-arming wins over a word taken in the same cycle
      if (arm_rise) begin
        sts_tready <= 1'b1;
        captured_q <= 1'b0;
      end else if (sts_acc) begin
        sts_tready <= 1'b0;
        captured_q <= 1'b1;
      end
      if (sts_acc) begin
        sts_data_q <= `FC_DATA_W'(sts_tdata);
      end
      sts_pf_q <= sts_prog_full;
    end
  end

  // Outstanding requests, a push and an accept together cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_cnt_q    <= '0;
      cnt_mirror_q <= '0;
    end else begin
      if (push_rise && !sts_acc) begin
        req_cnt_q <= req_cnt_q + 1'b1;
      end else if (!push_rise && sts_acc) begin
        req_cnt_q <= req_cnt_q - 1'b1;
      end
      cnt_mirror_q <= req_cnt_q;
    end
  end

  assign ctl.status = {8'h00, cnt_mirror_q, 4'h0, sts_pf_q, 1'b0, captured_q, arm_seen_q,
                       4'h0, cmd_pf_q, rdy_mirror_q, vld_mirror_q, push_seen_q};
  assign ctl.sts_data = sts_data_q;
  assign ctl.idle     = (req_cnt_q == '0);

endmodule

// ==== design/fifo_ctrl_consts.svh ====
`ifndef FIFO_CTRL_CONSTS_SVH
`define FIFO_CTRL_CONSTS_SVH

// AXI-Lite bus widths
`define FC_DATA_W 32
`define FC_ADDR_W 32

// Command pushed into each command FIFO, taken from four 32-bit words
`define FC_CMD_W     104
`define FC_CMD_WORDS 4

// Outstanding request counter per channel
`define FC_CNT_W 8

// Channel control bits, both act on their rising edge
`define FC_PUSH_BIT 0
`define FC_ARM_BIT  8

// Read value for addresses with no register
`define FC_RD_DEFAULT 32'h5a5aa5a5

`endif

// ==== design/fifo_ctrl_pkg.sv ====
`include "fifo_ctrl_consts.svh"

package fifo_ctrl_pkg;

  // Register map, byte addresses on the AXI-Lite port
  typedef enum logic [`FC_ADDR_W-1:0] {
    // SNAP block
    CONTROL        = 'h00,
    INT_ENABLE     = 'h04,
    ACTION_TYPE    = 'h10,
    ACTION_VERSION = 'h14,
    CONTEXT        = 'h20,
    // Transmit channel
    TX_STATUS      = 'h30,
    TX_CONTROL     = 'h34,
    TX_CMD0        = 'h38,
    TX_CMD1        = 'h3c,
    TX_CMD2        = 'h40,
    TX_CMD3        = 'h44,
    TX_STS_DATA    = 'h48,
    // Receive channel, same layout
    RX_STATUS      = 'h50,
    RX_CONTROL     = 'h54,
    RX_CMD0        = 'h58,
    RX_CMD1        = 'h5c,
    RX_CMD2        = 'h60,
    RX_CMD3        = 'h64,
    RX_STS_DATA    = 'h68
  } reg_addr_e;

endpackage

// ==== design/fifo_ctrl_top.sv ====
`include "fifo_ctrl_consts.svh"

module fifo_ctrl_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // AXI-Lite slave
  input  logic [`FC_ADDR_W-1:0]   s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  logic [`FC_DATA_W-1:0]   s_axi_wdata,
  input  logic [`FC_DATA_W/8-1:0] s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output logic [1:0]              s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  logic [`FC_ADDR_W-1:0]   s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output logic [`FC_DATA_W-1:0]   s_axi_rdata,
  output logic [1:0]              s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  // Transmit FIFOs
  output logic                    tx_cmd_tvalid,
  input  logic                    tx_cmd_tready,
  output logic [`FC_CMD_W-1:0]    tx_cmd_tdata,
  input  logic                    tx_cmd_prog_full,
  input  logic                    tx_sts_tvalid,
  output logic                    tx_sts_tready,
  input  logic [7:0]              tx_sts_tdata,
  input  logic                    tx_sts_prog_full,
  // Receive FIFOs
  output logic                    rx_cmd_tvalid,
  input  logic                    rx_cmd_tready,
  output logic [`FC_CMD_W-1:0]    rx_cmd_tdata,
  input  logic                    rx_cmd_prog_full,
  input  logic                    rx_sts_tvalid,
  output logic                    rx_sts_tready,
  input  logic [31:0]             rx_sts_tdata,
  input  logic                    rx_sts_prog_full,
  // SNAP identification and context
  input  logic [`FC_DATA_W-1:0]   action_type,
  input  logic [`FC_DATA_W-1:0]   action_version,
  output logic [`FC_DATA_W-1:0]   snap_context
);

  reg_bus_if bus ();
  chan_if    tx_ch ();
  chan_if    rx_ch ();

  axi_lite_port i_port (
    .clk     (clk),            .rst_n   (rst_n),
    .awaddr  (s_axi_awaddr),   .awvalid (s_axi_awvalid), .awready (s_axi_awready),
    .wdata   (s_axi_wdata),    .wstrb   (s_axi_wstrb),
    .wvalid  (s_axi_wvalid),   .wready  (s_axi_wready),
    .bresp   (s_axi_bresp),    .bvalid  (s_axi_bvalid),  .bready  (s_axi_bready),
    .araddr  (s_axi_araddr),   .arvalid (s_axi_arvalid), .arready (s_axi_arready),
    .rdata   (s_axi_rdata),    .rresp   (s_axi_rresp),
    .rvalid  (s_axi_rvalid),   .rready  (s_axi_rready),
    .bus     (bus.port)
  );

  ctrl_regs i_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .bus            (bus.regs),
    .tx             (tx_ch.regs),
    .rx             (rx_ch.regs),
    .action_type    (action_type),
    .action_version (action_version),
    .snap_context   (snap_context)
  );

  fifo_channel #(.STS_W(8)) i_tx (
    .clk           (clk),              .rst_n         (rst_n),
    .ctl           (tx_ch.chan),
    .cmd_tvalid    (tx_cmd_tvalid),    .cmd_tready    (tx_cmd_tready),
    .cmd_tdata     (tx_cmd_tdata),     .cmd_prog_full (tx_cmd_prog_full),
    .sts_tvalid    (tx_sts_tvalid),    .sts_tready    (tx_sts_tready),
    .sts_tdata     (tx_sts_tdata),     .sts_prog_full (tx_sts_prog_full)
  );

  fifo_channel #(.STS_W(32)) i_rx (
    .clk           (clk),              .rst_n         (rst_n),
    .ctl           (rx_ch.chan),
    .cmd_tvalid    (rx_cmd_tvalid),    .cmd_tready    (rx_cmd_tready),
    .cmd_tdata     (rx_cmd_tdata),     .cmd_prog_full (rx_cmd_prog_full),
    .sts_tvalid    (rx_sts_tvalid),    .sts_tready    (rx_sts_tready),
    .sts_tdata     (rx_sts_tdata),     .sts_prog_full (rx_sts_prog_full)
  );

endmodule

// ==== design/reg_bus_if.sv ====
`include "fifo_ctrl_consts.svh"

interface reg_bus_if;

  // Write strobe and its payload, valid for one cycle
  logic                     wr_en;
  logic [`FC_ADDR_W-1:0]    wr_addr;
  logic [`FC_DATA_W-1:0]    wr_data;
  logic [`FC_DATA_W/8-1:0]  wr_strb;

  // Read strobe, rd_data follows rd_addr combinationally
  logic                     rd_en;
  logic [`FC_ADDR_W-1:0]    rd_addr;
  logic [`FC_DATA_W-1:0]    rd_data;

  modport port (output wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr, input rd_data);
  modport regs (input wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr, output rd_data);

endinterface

// ==== files.f ====
+incdir+design
design/fifo_ctrl_pkg.sv
design/reg_bus_if.sv
design/chan_if.sv
design/axi_lite_port.sv
design/ctrl_regs.sv
design/fifo_channel.sv
design/fifo_ctrl_top.sv
verification/tb_fifo_ctrl.sv

// ==== verification/tb_fifo_ctrl.sv ====
`include "fifo_ctrl_consts.svh"

module tb_fifo_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAND = 40;
  // Upper bound on bus transactions over the whole run
  localparam int N_TRANS = 2 * N_RAND + 100;
  localparam logic [31:0] STATUS_MASK = 32'h00ff_0b0d;

  logic                    clk;
  logic                    rst_n;
  logic [`FC_ADDR_W-1:0]   awaddr;
  logic                    awvalid;
  logic [`FC_DATA_W-1:0]   wdata;
  logic [`FC_DATA_W/8-1:0] wstrb;
  logic                    wvalid;
  logic                    bready;
  logic [`FC_ADDR_W-1:0]   araddr;
  logic                    arvalid;
  logic                    rready;
  wire                     awready;
  wire                     wready;
  wire                     bvalid;
  wire                     arready;
  wire                     rvalid;
  wire  [1:0]              bresp;
  wire  [1:0]              rresp;
  wire  [`FC_DATA_W-1:0]   rdata;
  // Index 0 is transmit and index 1 receive
  logic [1:0]              cmd_tready;
  logic [1:0]              cmd_pf;
  logic [1:0]              sts_tvalid;
  logic [1:0]              sts_pf;
  wire  [1:0]              cmd_tvalid;
  wire  [1:0]              sts_tready;
  wire  [`FC_CMD_W-1:0]    tx_cmd_tdata;
  wire  [`FC_CMD_W-1:0]    rx_cmd_tdata;
  logic [7:0]              tx_sts_tdata;
  logic [31:0]             rx_sts_tdata;
  logic [31:0]             action_type;
  logic [31:0]             action_version;
  wire  [31:0]             snap_context;

  logic [31:0] lfsr;
  int          errors;
  int          checks;

  // Reference model
  logic [31:0] snap_ctrl_m;
  logic [31:0] int_enable_m;
  logic [31:0] context_m;
  logic [31:0] ctrl_m [2];
  logic [31:0] cmd_m [2][4];
  logic [31:0] sts_m [2];
  logic [7:0]  cnt_m [2];
  logic        cap_m [2];

  fifo_ctrl_top i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .s_axi_awaddr     (awaddr),
    .s_axi_awvalid    (awvalid),
    .s_axi_awready    (awready),
    .s_axi_wdata      (wdata),
    .s_axi_wstrb      (wstrb),
    .s_axi_wvalid     (wvalid),
    .s_axi_wready     (wready),
    .s_axi_bresp      (bresp),
    .s_axi_bvalid     (bvalid),
    .s_axi_bready     (bready),
    .s_axi_araddr     (araddr),
    .s_axi_arvalid    (arvalid),
    .s_axi_arready    (arready),
    .s_axi_rdata      (rdata),
    .s_axi_rresp      (rresp),
    .s_axi_rvalid     (rvalid),
    .s_axi_rready     (rready),
    .tx_cmd_tvalid    (cmd_tvalid[0]),
    .tx_cmd_tready    (cmd_tready[0]),
    .tx_cmd_tdata     (tx_cmd_tdata),
    .tx_cmd_prog_full (cmd_pf[0]),
    .tx_sts_tvalid    (sts_tvalid[0]),
    .tx_sts_tready    (sts_tready[0]),
    .tx_sts_tdata     (tx_sts_tdata),
    .tx_sts_prog_full (sts_pf[0]),
    .rx_cmd_tvalid    (cmd_tvalid[1]),
    .rx_cmd_tready    (cmd_tready[1]),
    .rx_cmd_tdata     (rx_cmd_tdata),
    .rx_cmd_prog_full (cmd_pf[1]),
    .rx_sts_tvalid    (sts_tvalid[1]),
    .rx_sts_tready    (sts_tready[1]),
    .rx_sts_tdata     (rx_sts_tdata),
    .rx_sts_prog_full (sts_pf[1]),
    .action_type      (action_type),
    .action_version   (action_version),
    .snap_context     (snap_context)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Random source and model helpers
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [31:0] lane_merge(input logic [31:0] old_v, input logic [31:0] new_v,
                                             input logic [3:0] strb);
    logic [31:0] v;
    v = old_v;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        v[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return v;
  endfunction

  // Receive registers sit 20h above their transmit twins
  function automatic logic [31:0] chan_addr(input int c, input logic [31:0] tx_addr);
    return (c == 0) ? tx_addr : tx_addr + 32'h20;
  endfunction

  // Indices 0 to 2 are SNAP registers and 3 to 12 the channel registers
  function automatic logic [31:0] rw_addr(input int idx);
    if (idx == 0) return fifo_ctrl_pkg::CONTROL;
    if (idx == 1) return fifo_ctrl_pkg::INT_ENABLE;
    if (idx == 2) return fifo_ctrl_pkg::CONTEXT;
    return chan_addr((idx - 3) / 5, fifo_ctrl_pkg::TX_CONTROL + 4 * ((idx - 3) % 5));
  endfunction

  function automatic logic is_mapped(input logic [31:0] addr);
    if (addr[1:0] != 2'b00 || addr > 32'h68) return 1'b0;
    case (addr)
      32'h08, 32'h0c, 32'h18, 32'h1c, 32'h24, 32'h28, 32'h2c, 32'h4c: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
    if (addr == fifo_ctrl_pkg::CONTROL) snap_ctrl_m = lane_merge(snap_ctrl_m, data, strb);
    if (addr == fifo_ctrl_pkg::INT_ENABLE) int_enable_m = lane_merge(int_enable_m, data, strb);
    if (addr == fifo_ctrl_pkg::CONTEXT) context_m = lane_merge(context_m, data, strb);
    for (int c = 0; c < 2; c++) begin
      if (addr == chan_addr(c, fifo_ctrl_pkg::TX_CONTROL)) begin
        ctrl_m[c] = lane_merge(ctrl_m[c], data, strb);
      end
      for (int k = 0; k < 4; k++) begin
        if (addr == chan_addr(c, fifo_ctrl_pkg::TX_CMD0 + 4 * k)) begin
          cmd_m[c][k] = lane_merge(cmd_m[c][k], data, strb);
        end
      end
    end
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic idle;
    idle = (cnt_m[0] == 0) && (cnt_m[1] == 0);
    if (addr == fifo_ctrl_pkg::CONTROL) begin
      return {snap_ctrl_m[31:4], 1'b1, idle, 1'b0, snap_ctrl_m[0]};
    end
    if (addr == fifo_ctrl_pkg::INT_ENABLE) return int_enable_m;
    if (addr == fifo_ctrl_pkg::ACTION_TYPE) return action_type;
    if (addr == fifo_ctrl_pkg::ACTION_VERSION) return action_version;
    if (addr == fifo_ctrl_pkg::CONTEXT) return context_m;
    for (int c = 0; c < 2; c++) begin
      if (addr == chan_addr(c, fifo_ctrl_pkg::TX_CONTROL)) return ctrl_m[c];
      if (addr == chan_addr(c, fifo_ctrl_pkg::TX_STS_DATA)) return sts_m[c];
      for (int k = 0; k < 4; k++) begin
        if (addr == chan_addr(c, fifo_ctrl_pkg::TX_CMD0 + 4 * k)) return cmd_m[c][k];
      end
    end
    return `FC_RD_DEFAULT;
  endfunction

  function automatic logic [`FC_CMD_W-1:0] cmd_data(input int c);
    return (c == 0) ? tx_cmd_tdata : rx_cmd_tdata;
  endfunction

  ////////////////////////////////////////
  // Bus tasks enter and leave on a falling edge
  ////////////////////////////////////////

  task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int hold;
    hold = rand_bits(2);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    while (!awready) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    while (!wready) @(negedge clk);
    @(negedge clk);
    wvalid = 1'b0;
    // Response must wait for the master
    repeat (hold) @(negedge clk);
    if (!bvalid) begin
      errors++;
      $display("Write to %h gave no response held for the master", addr);
    end
    check_eq("bresp", bresp, 2'b00);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
    int hold;
    hold = rand_bits(2);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    repeat (hold) @(negedge clk);
    if (!rvalid) begin
      errors++;
      $display("Read of %h gave no data held for the master", addr);
    end
    check_eq("rresp", rresp, 2'b00);
    data   = rdata;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic check_read(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    string       name;
    axi_read(addr, got);
    name = $sformatf("rdata at %h", addr);
    check_eq(name, got, exp);
  endtask

  task automatic check_status(input int c);
    logic [31:0] got;
    logic [31:0] exp;
    // Status flags are mirrored one cycle late
    cmd_pf[c]     = lfsr_bit();
    sts_pf[c]     = lfsr_bit();
    cmd_tready[c] = lfsr_bit();
    @(negedge clk);
    exp = {8'h00, cnt_m[c], 4'h0, sts_pf[c], 1'b0, cap_m[c], ctrl_m[c][8],
           4'h0, cmd_pf[c], cmd_tready[c], 1'b0, ctrl_m[c][0]};
    axi_read(chan_addr(c, fifo_ctrl_pkg::TX_STATUS), got);
    check_eq((c == 0) ? "tx status" : "rx status", got & STATUS_MASK, exp);
  endtask

  task automatic write_model(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    axi_write(addr, data, strb);
    model_write(addr, data, strb);
  endtask

  ////////////////////////////////////////
  // Test phases
  ////////////////////////////////////////

  task automatic rand_reg_test();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    for (int i = 0; i < N_RAND; i++) begin
      addr = rw_addr(rand_bits(4) % 13);
      data = rand_bits(32);
      strb = rand_bits(4);
      // Channel push and arm bits stay clear here
      if (addr == chan_addr(0, fifo_ctrl_pkg::TX_CONTROL) ||
          addr == chan_addr(1, fifo_ctrl_pkg::TX_CONTROL)) begin
        data = data & ~32'h0000_0101;
      end
      write_model(addr, data, strb);
      check_read(addr, model_read(addr));
      check_eq("snap_context", snap_context, context_m);
    end
  endtask

  task automatic ident_test();
    logic [31:0] addr;
    action_type    = rand_bits(32);
    action_version = rand_bits(32);
    check_read(fifo_ctrl_pkg::ACTION_TYPE, action_type);
    check_read(fifo_ctrl_pkg::ACTION_VERSION, action_version);
    for (int a = 0; a < 'h80; a += 4) begin
      if (!is_mapped(a)) check_read(a, `FC_RD_DEFAULT);
    end
    repeat (8) begin
      addr = rand_bits(8);
      if (!is_mapped(addr)) check_read(addr, `FC_RD_DEFAULT);
    end
  endtask

  task automatic push_cmd(input int c);
    logic [4*32-1:0] words;
    logic [31:0]     ctrl;
    int              hold;
    int              wait_cnt;
    for (int k = 0; k < 4; k++) begin
      write_model(chan_addr(c, fifo_ctrl_pkg::TX_CMD0 + 4 * k), rand_bits(32), 4'hf);
    end
    words = {cmd_m[c][3], cmd_m[c][2], cmd_m[c][1], cmd_m[c][0]};
    ctrl  = chan_addr(c, fifo_ctrl_pkg::TX_CONTROL);
    cmd_tready[c] = 1'b0;
    write_model(ctrl, ctrl_m[c] | 32'h1, 4'hf);
    cnt_m[c] = cnt_m[c] + 1;
    wait_cnt = 0;
    while (!cmd_tvalid[c] && wait_cnt < 20) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!cmd_tvalid[c]) begin
      errors++;
      $display("Command valid did not rise after the push bit was set");
    end
    // Back-pressure for a random number of cycles
    hold = rand_bits(3);
    for (int i = 0; i <= hold; i++) begin
      if (i > 0) @(negedge clk);
      check_eq("cmd_tvalid", cmd_tvalid[c], 1'b1);
      check_eq("cmd_tdata", cmd_data(c), words[`FC_CMD_W-1:0]);
    end
    cmd_tready[c] = 1'b1;
    // No second push while bit 0 stays set
    repeat (6) begin
      @(negedge clk);
      check_eq("cmd_tvalid", cmd_tvalid[c], 1'b0);
    end
    cmd_tready[c] = 1'b0;
    write_model(ctrl, ctrl_m[c] & ~32'h1, 4'hf);
  endtask

  task automatic capture_sts(input int c);
    logic [31:0] d;
    logic        rdy;
    logic [31:0] ctrl;
    ctrl = chan_addr(c, fifo_ctrl_pkg::TX_CONTROL);
    for (int i = 0; i < 4; i++) begin
      rdy = sts_tready[c];
      d = rand_bits(32);
      tx_sts_tdata  = d[7:0];
      rx_sts_tdata  = d;
      sts_tvalid[c] = 1'b1;
      check_eq("sts_tready", rdy, i == 0);
      // Only the first word is taken
      if (i == 0) sts_m[c] = (c == 0) ? {24'h0, d[7:0]} : d;
      @(negedge clk);
    end
    sts_tvalid[c] = 1'b0;
    cnt_m[c] = cnt_m[c] - 1;
    cap_m[c] = 1'b1;
    check_read(chan_addr(c, fifo_ctrl_pkg::TX_STS_DATA), sts_m[c]);
    check_status(c);
    check_read(fifo_ctrl_pkg::CONTROL, model_read(fifo_ctrl_pkg::CONTROL));
    // Re-arm
    write_model(ctrl, ctrl_m[c] | 32'h100, 4'hf);
    cap_m[c] = 1'b0;
    check_status(c);
    check_eq("sts_tready", sts_tready[c], 1'b1);
    write_model(ctrl, ctrl_m[c] & ~32'h100, 4'hf);
  endtask

  ////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////

  initial begin
    rst_n          = 1'b0;
    awaddr         = '0;
    awvalid        = 1'b0;
    wdata          = '0;
    wstrb          = '0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    araddr         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    cmd_tready     = '0;
    cmd_pf         = '0;
    sts_tvalid     = '0;
    sts_pf         = '0;
    tx_sts_tdata   = '0;
    rx_sts_tdata   = '0;
    action_type    = '0;
    action_version = '0;
    lfsr           = 32'h3d82;
    errors         = 0;
    checks         = 0;
    snap_ctrl_m    = '0;
    int_enable_m   = '0;
    context_m      = '0;
    for (int c = 0; c < 2; c++) begin
      ctrl_m[c] = '0;
      sts_m[c]  = '0;
      cnt_m[c]  = '0;
      cap_m[c]  = 1'b0;
      for (int k = 0; k < 4; k++) begin
        cmd_m[c][k] = '0;
      end
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    rand_reg_test();
    ident_test();
    // Counts go up on pushes and back down on captures
    push_cmd(0);
    check_status(0);
    check_read(fifo_ctrl_pkg::CONTROL, model_read(fifo_ctrl_pkg::CONTROL));
    push_cmd(1);
    check_status(1);
    push_cmd(0);
    check_status(0);
    check_read(fifo_ctrl_pkg::CONTROL, model_read(fifo_ctrl_pkg::CONTROL));
    capture_sts(0);
    capture_sts(1);
    capture_sts(0);
    for (int i = 0; i < 13; i++) begin
      check_read(rw_addr(i), model_read(rw_addr(i)));
    end
    check_eq("snap_context", snap_context, context_m);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    repeat (N_TRANS * 50) @(posedge clk);
    $display("Timeout after %0d cycles, test sequence did not complete", N_TRANS * 50);
    $display("Finished with errors");
    $finish;
  end

endmodule
